// ==== dsp_pkg.sv ====
package dsp_pkg;

  ////////////////////////////////////////
  // sample and arithmetic widths
  ////////////////////////////////////////

  localparam int SAMP_W = 12;  // input I and Q width

  localparam int DEC_RATE  = 4;  // boxcar length, must be a power of two
  localparam int DEC_SHIFT = 2;  // log2 of DEC_RATE

  localparam int LEN   = 16;  // correlation window in decimated samples
  localparam int LEN_W = 4;   // index width of the window ring

  localparam int PROD_W = 25;  // two 24-bit products summed
  localparam int ACC_W  = 29;  // PROD_W plus growth over LEN terms

  ////////////////////////////////////////
  // complex types
  ////////////////////////////////////////

  // used for raw input and for decimated samples alike
  typedef struct packed {
    logic signed [SAMP_W-1:0] re;
    logic signed [SAMP_W-1:0] im;
  } cplx_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] re;
    logic signed [ACC_W-1:0] im;
  } acc_cplx_t;

endpackage

// ==== detect_pkg.sv ====
package detect_pkg;

  ////////////////////////////////////////
  // detector controls
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    TH_QUARTER,        // pow / 4
    TH_THREE_EIGHTHS,  // pow / 4 + pow / 8
    TH_HALF,           // pow / 2
    TH_FIVE_EIGHTHS    // pow / 2 + pow / 8
  } thres_sel_e;

  typedef enum logic {
    ST_SEARCH,
    ST_LOCKED
  } det_state_e;

  localparam int          NRX_TRIG   = 4;     // consecutive triggers needed for a report
  localparam int unsigned NOISE_POW  = 2000;  // power must exceed this floor
  localparam int          RES_DEPTH  = 4;     // result FIFO slots
  localparam int          IN_CREDITS = 4;     // credits the sender owns after reset
  localparam int          IDX_W      = 16;    // decimated sample index width
  localparam int          OUT_CRED_W = 8;     // output credit counter width

  ////////////////////////////////////////
  // report format
  ////////////////////////////////////////

  typedef struct packed {
    logic [IDX_W-1:0]         idx;
    logic [dsp_pkg::ACC_W-1:0] corr_mag;
    logic [dsp_pkg::ACC_W-1:0] pow_mag;
  } det_result_t;

endpackage

// ==== sample_decimate.sv ====
`timescale 1ns/1ns

module sample_decimate (
  input  logic           clk,
  input  logic           i_rst,
  input  logic           i_clear,
  input  logic           i_valid,
  input  dsp_pkg::cplx_t i_sample,
  input  logic           i_space_low,
  output logic           o_credit,
  output logic           o_dec_valid,
  output dsp_pkg::cplx_t o_dec_sample
);
  import dsp_pkg::*;
  import detect_pkg::*;

  logic [DEC_SHIFT-1:0]                 phase;
  logic signed [SAMP_W+DEC_SHIFT-1:0]   sum_re;
  logic signed [SAMP_W+DEC_SHIFT-1:0]   sum_im;
  logic signed [SAMP_W+DEC_SHIFT-1:0]   next_re;
  logic signed [SAMP_W+DEC_SHIFT-1:0]   next_im;
  logic signed [SAMP_W+DEC_SHIFT-1:0]   avg_re;
  logic signed [SAMP_W+DEC_SHIFT-1:0]   avg_im;
  logic                                 last_in;
  logic [$clog2(IN_CREDITS+1)-1:0]      pend_cnt;

  ////////////////////////////////////////
  // boxcar average
  ////////////////////////////////////////

  always_comb begin
    next_re = sum_re + i_sample.re;  // sign-extended into the wider sum
    next_im = sum_im + i_sample.im;
    avg_re  = next_re >>> DEC_SHIFT;
    avg_im  = next_im >>> DEC_SHIFT;
    last_in = i_valid && (phase == DEC_SHIFT'(DEC_RATE - 1));
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      phase       <= '0;
      sum_re      <= '0;
      sum_im      <= '0;
      o_dec_valid <= 1'b0;
    end else begin
      o_dec_valid <= last_in;
      if (i_valid) begin
        phase <= phase + 1'b1;  // wraps after DEC_RATE samples
        if (last_in) begin
          sum_re <= '0;
          sum_im <= '0;
        end else begin
          sum_re <= next_re;
          sum_im <= next_im;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (last_in) begin
      o_dec_sample.re <= avg_re[SAMP_W-1:0];  // average always fits SAMP_W
      o_dec_sample.im <= avg_im[SAMP_W-1:0];
    end
  end

  ////////////////////////////////////////
  // input credit return
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      pend_cnt <= '0;
      o_credit <= 1'b0;
    end else if (i_space_low) begin
      o_credit <= 1'b0;  // hold credits back until the FIFO drains
      if (i_valid) begin
        pend_cnt <= pend_cnt + 1'b1;
      end
    end else if (pend_cnt != '0) begin
      o_credit <= 1'b1;
      if (!i_valid) begin
        pend_cnt <= pend_cnt - 1'b1;
      end
    end else begin
      o_credit <= i_valid;
    end
  end

endmodule

// ==== delay_corr.sv ====
`timescale 1ns/1ns

module delay_corr (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_clear,
  input  logic                      i_dec_valid,
  input  dsp_pkg::cplx_t            i_dec_sample,
  output logic                      o_met_valid,
  output logic [dsp_pkg::ACC_W-1:0] o_corr_mag,
  output logic [dsp_pkg::ACC_W-1:0] o_pow_mag
);
  import dsp_pkg::*;

  typedef struct packed {
    logic signed [PROD_W-1:0] re;
    logic signed [PROD_W-1:0] im;
  } prod_cplx_t;

  // stage 1, sample delay line and products
  cplx_t                    samp_ring [LEN];
  logic [LEN_W-1:0]         samp_ptr;
  cplx_t                    old_sample;
  prod_cplx_t               corr_prod;
  logic signed [PROD_W-1:0] pow_prod;
  prod_cplx_t               corr_prod_q;
  logic signed [PROD_W-1:0] pow_prod_q;
  logic [LEN_W-1:0]         s1_ptr;
  logic                     s1_valid;

  // stage 2, product rings and running sums
  prod_cplx_t               corr_ring [LEN];
  logic signed [PROD_W-1:0] pow_ring [LEN];
  acc_cplx_t                corr_sum;
  logic signed [ACC_W-1:0]  pow_sum;
  acc_cplx_t                pow_cplx;
  logic                     s2_valid;

  // larger absolute component plus half the smaller
  function automatic logic [ACC_W-1:0] mag_approx(input acc_cplx_t v);
    logic [ACC_W-1:0] a_re;
    logic [ACC_W-1:0] a_im;
    a_re = (v.re < 0) ? -v.re : v.re;
    a_im = (v.im < 0) ? -v.im : v.im;
    if (a_re >= a_im) begin
      return a_re + (a_im >> 1);
    end
    return a_im + (a_re >> 1);
  endfunction

  ////////////////////////////////////////
  // stage 1
  ////////////////////////////////////////

  always_comb begin
    old_sample   = samp_ring[samp_ptr];  // x[n-LEN]
    corr_prod.re = i_dec_sample.re * old_sample.re + i_dec_sample.im * old_sample.im;
    corr_prod.im = i_dec_sample.im * old_sample.re - i_dec_sample.re * old_sample.im;
    pow_prod     = i_dec_sample.re * i_dec_sample.re + i_dec_sample.im * i_dec_sample.im;
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      for (int k = 0; k < LEN; k++) begin
        samp_ring[k] <= '0;
      end
      samp_ptr <= '0;
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= i_dec_valid;
      if (i_dec_valid) begin
        samp_ring[samp_ptr] <= i_dec_sample;
        samp_ptr            <= samp_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_dec_valid) begin
      corr_prod_q <= corr_prod;
      pow_prod_q  <= pow_prod;
      s1_ptr      <= samp_ptr;  // same slot is reused in the product rings
    end
  end

  ////////////////////////////////////////
  // stage 2
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      for (int k = 0; k < LEN; k++) begin
        corr_ring[k] <= '0;
        pow_ring[k]  <= '0;
      end
      corr_sum <= '0;
      pow_sum  <= '0;
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      if (s1_valid) begin
        corr_sum.re       <= corr_sum.re + corr_prod_q.re - corr_ring[s1_ptr].re;
        corr_sum.im       <= corr_sum.im + corr_prod_q.im - corr_ring[s1_ptr].im;
        pow_sum           <= pow_sum + pow_prod_q - pow_ring[s1_ptr];
        corr_ring[s1_ptr] <= corr_prod_q;
        pow_ring[s1_ptr]  <= pow_prod_q;
      end
    end
  end

  ////////////////////////////////////////
  // stage 3
  ////////////////////////////////////////

  always_comb begin
    pow_cplx.re = pow_sum;
    pow_cplx.im = '0;  // power has no imaginary part
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      o_met_valid <= 1'b0;
    end else begin
      o_met_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      o_corr_mag <= mag_approx(corr_sum);
      o_pow_mag  <= mag_approx(pow_cplx);
    end
  end

endmodule

// ==== peak_judge.sv ====
`timescale 1ns/1ns

module peak_judge (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_clear,
  input  detect_pkg::thres_sel_e    i_thres_sel,
  input  logic                      i_met_valid,
  input  logic [dsp_pkg::ACC_W-1:0] i_corr_mag,
  input  logic [dsp_pkg::ACC_W-1:0] i_pow_mag,
  input  logic                      i_credit,
  output logic                      o_space_low,
  output logic                      o_valid,
  output detect_pkg::det_result_t   o_result
);
  import dsp_pkg::*;
  import detect_pkg::*;

  logic [ACC_W-1:0]                 thres;
  logic                             trig;
  det_state_e                       state;
  logic [$clog2(NRX_TRIG+1)-1:0]    run_cnt;
  logic [IDX_W-1:0]                 idx;
  logic                             push_req;
  logic                             push;
  logic                             pop;

  det_result_t                      fifo_mem [RES_DEPTH];
  logic [$clog2(RES_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(RES_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(RES_DEPTH+1)-1:0]   fifo_cnt;
  logic [OUT_CRED_W-1:0]            out_cred;

  ////////////////////////////////////////
  // threshold and trigger
  ////////////////////////////////////////

  always_comb begin
    thres = i_pow_mag >> 2;
    case (i_thres_sel)
      TH_QUARTER:       thres = i_pow_mag >> 2;
      TH_THREE_EIGHTHS: thres = (i_pow_mag >> 2) + (i_pow_mag >> 3);
      TH_HALF:          thres = i_pow_mag >> 1;
      TH_FIVE_EIGHTHS:  thres = (i_pow_mag >> 1) + (i_pow_mag >> 3);
      default:          thres = i_pow_mag >> 2;
    endcase
    trig     = (i_corr_mag > thres) && (i_pow_mag > NOISE_POW);
    push_req = i_met_valid && trig && (state == ST_SEARCH) && (run_cnt == NRX_TRIG - 1);
    push     = push_req && (fifo_cnt != RES_DEPTH);
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      state   <= ST_SEARCH;
      run_cnt <= '0;
      idx     <= '0;
    end else if (i_met_valid) begin
      idx <= idx + 1'b1;  // counts every metric, reported or not
      case (state)
        ST_SEARCH: begin
          if (!trig) begin
            run_cnt <= '0;
          end else if (push_req) begin
            run_cnt <= '0;
            state   <= ST_LOCKED;
          end else begin
            run_cnt <= run_cnt + 1'b1;
          end
        end
        ST_LOCKED: begin
          if (!trig) begin
            state <= ST_SEARCH;  // one quiet metric rearms the search
          end
        end
        default: state <= ST_SEARCH;
      endcase
    end
  end

  ////////////////////////////////////////
  // result FIFO and output credits
  ////////////////////////////////////////

  always_comb begin
    o_valid     = (fifo_cnt != '0) && (out_cred != '0);
    pop         = o_valid;
    o_result    = fifo_mem[rd_ptr];
    o_space_low = fifo_cnt > RES_DEPTH - 2;  // fewer than two free slots
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= '{idx: idx, corr_mag: i_corr_mag, pow_mag: i_pow_mag};
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      out_cred <= '0;
    end else begin
      case ({i_credit, pop})
        2'b10:   out_cred <= out_cred + 1'b1;
        2'b01:   out_cred <= out_cred - 1'b1;
        default: out_cred <= out_cred;
      endcase
    end
  end

endmodule

// ==== preamble_top.sv ====
`timescale 1ns/1ns

module preamble_top (
  input  logic                    clk,
  input  logic                    i_rst,
  input  logic                    i_clear,
  input  detect_pkg::thres_sel_e  i_thres_sel,
  input  logic                    i_valid,
  input  dsp_pkg::cplx_t          i_sample,
  output logic                    o_credit,
  input  logic                    i_credit,
  output logic                    o_valid,
  output detect_pkg::det_result_t o_result
);
  import dsp_pkg::*;

  logic             dec_valid;
  cplx_t            dec_sample;
  logic             met_valid;
  logic [ACC_W-1:0] met_corr_mag;
  logic [ACC_W-1:0] met_pow_mag;
  logic             res_space_low;

  ////////////////////////////////////////
  // decimate, correlate, judge
  ////////////////////////////////////////

  sample_decimate sample_decimate_i (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_clear      (i_clear),
    .i_valid      (i_valid),
    .i_sample     (i_sample),
    .i_space_low  (res_space_low),  // withholds input credits
    .o_credit     (o_credit),
    .o_dec_valid  (dec_valid),
    .o_dec_sample (dec_sample)
  );

  delay_corr delay_corr_i (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_clear      (i_clear),
    .i_dec_valid  (dec_valid),
    .i_dec_sample (dec_sample),
    .o_met_valid  (met_valid),
    .o_corr_mag   (met_corr_mag),
    .o_pow_mag    (met_pow_mag)
  );

  peak_judge peak_judge_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_clear     (i_clear),
    .i_thres_sel (i_thres_sel),
    .i_met_valid (met_valid),
    .i_corr_mag  (met_corr_mag),
    .i_pow_mag   (met_pow_mag),
    .i_credit    (i_credit),
    .o_space_low (res_space_low),
    .o_valid     (o_valid),
    .o_result    (o_result)
  );

endmodule

// ==== tb_preamble_top.sv ====
`timescale 1ns/1ns

module tb_preamble_top;
  import dsp_pkg::*;
  import detect_pkg::*;

  localparam logic [31:0] SEED = 32'h92c7_7b7e;

  localparam int PRE_LEN       = 64 + 4 * LEN * DEC_RATE + 64;  // noise, four repeats, noise
  localparam int BURST_LEN     = 8 * (64 + 2 * LEN * DEC_RATE) + 64;
  localparam int CUT_LEN       = 150;  // stops inside a decimation group
  localparam int TOTAL_SAMPLES = 256 + 4 * PRE_LEN + BURST_LEN + CUT_LEN + PRE_LEN;
  localparam int MAX_CYCLES    = 10 * TOTAL_SAMPLES + 2000;

  logic        clk;
  logic        i_rst;
  logic        i_clear;
  thres_sel_e  i_thres_sel;
  logic        i_valid;
  cplx_t       i_sample;
  logic        o_credit;
  logic        i_credit;
  logic        o_valid;
  det_result_t o_result;

  logic [31:0] stim_rng;
  logic [31:0] grant_rng;
  logic [7:0]  grant_mask;
  logic        grant_hold;
  logic        rst_q;
  det_result_t exp_q [$];
  cplx_t       stim_q [$];
  cplx_t       pre_q [$];
  int          sent;
  int          credits_back;
  int          granted;
  int          received;
  int          cycles;

  preamble_top preamble_top_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_clear     (i_clear),
    .i_thres_sel (i_thres_sel),
    .i_valid     (i_valid),
    .i_sample    (i_sample),
    .o_credit    (o_credit),
    .i_credit    (i_credit),
    .o_valid     (o_valid),
    .o_result    (o_result)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // uniform integer in [-amp, amp]
  function automatic int next_val(input int amp);
    stim_rng = xorshift32(stim_rng);
    return int'(stim_rng[15:0] % (2 * amp + 1)) - amp;
  endfunction

  function automatic longint abs_mag(input longint a, input longint b);
    longint ma;
    longint mb;
    ma = (a < 0) ? -a : a;
    mb = (b < 0) ? -b : b;
    if (ma >= mb) begin
      return ma + mb / 2;
    end
    return mb + ma / 2;
  endfunction

  // runs one stream from a cleared detector and queues the reports it must give
  function automatic void model_segment(input cplx_t samp[$], input thres_sel_e sel);
    longint      acc_re;
    longint      acc_im;
    longint      x_re [LEN];
    longint      x_im [LEN];
    longint      c_re [LEN];
    longint      c_im [LEN];
    longint      p_ring [LEN];
    longint      n_re;
    longint      n_im;
    longint      pr_re;
    longint      pr_im;
    longint      pr_p;
    longint      sum_re;
    longint      sum_im;
    longint      sum_p;
    longint      corr_mag;
    longint      pow_mag;
    longint      thres;
    bit          trig;
    int          slot;
    int          run;
    int          idx;
    det_state_e  state;
    det_result_t res;
    acc_re = 0;
    acc_im = 0;
    sum_re = 0;
    sum_im = 0;
    sum_p  = 0;
    run    = 0;
    idx    = 0;
    state  = ST_SEARCH;
    for (int k = 0; k < LEN; k++) begin
      x_re[k]   = 0;
      x_im[k]   = 0;
      c_re[k]   = 0;
      c_im[k]   = 0;
      p_ring[k] = 0;
    end
    for (int s = 0; s < samp.size(); s++) begin
      acc_re += samp[s].re;
      acc_im += samp[s].im;
      if (s % DEC_RATE == DEC_RATE - 1) begin
        n_re   = acc_re >>> DEC_SHIFT;
        n_im   = acc_im >>> DEC_SHIFT;
        acc_re = 0;
        acc_im = 0;
        slot   = idx % LEN;  // holds x[n-LEN] and its products
        pr_re  = n_re * x_re[slot] + n_im * x_im[slot];
        pr_im  = n_im * x_re[slot] - n_re * x_im[slot];
        pr_p   = n_re * n_re + n_im * n_im;
        sum_re += pr_re - c_re[slot];
        sum_im += pr_im - c_im[slot];
        sum_p  += pr_p - p_ring[slot];
        x_re[slot]   = n_re;
        x_im[slot]   = n_im;
        c_re[slot]   = pr_re;
        c_im[slot]   = pr_im;
        p_ring[slot] = pr_p;
        corr_mag = abs_mag(sum_re, sum_im);
        pow_mag  = abs_mag(sum_p, 0);
        case (sel)
          TH_QUARTER:       thres = pow_mag >> 2;
          TH_THREE_EIGHTHS: thres = (pow_mag >> 2) + (pow_mag >> 3);
          TH_HALF:          thres = pow_mag >> 1;
          default:          thres = (pow_mag >> 1) + (pow_mag >> 3);
        endcase
        trig = (corr_mag > thres) && (pow_mag > longint'(NOISE_POW));
        if (state == ST_SEARCH) begin
          if (!trig) begin
            run = 0;
          end else if (run == NRX_TRIG - 1) begin
            res.idx      = IDX_W'(idx);
            res.corr_mag = ACC_W'(corr_mag);
            res.pow_mag  = ACC_W'(pow_mag);
            exp_q.push_back(res);
            run   = 0;
            state = ST_LOCKED;
          end else begin
            run++;
          end
        end else if (!trig) begin
          state = ST_SEARCH;
        end
        idx++;
      end
    end
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_result(input det_result_t got, input det_result_t want);
    if (got !== want) begin
      $display("Error at %0t ns: got idx %0d corr_mag %0d pow_mag %0d", $time,
               got.idx, got.corr_mag, got.pow_mag);
      $display("Error at %0t ns: expected idx %0d corr_mag %0d pow_mag %0d", $time,
               want.idx, want.corr_mag, want.pow_mag);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int want);
    if (got != want) begin
      $display("Error at %0t ns: %0d input credits returned, expected %0d", $time, got, want);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic add_noise(input int n, input int amp);
    cplx_t s;
    for (int k = 0; k < n; k++) begin
      s.re = SAMP_W'(next_val(amp));
      s.im = SAMP_W'(next_val(amp));
      stim_q.push_back(s);
    end
  endtask

  // a random pattern of LEN decimated values, each held DEC_RATE inputs with light noise
  task automatic add_preamble(input int reps, input int amp);
    cplx_t pat [LEN];
    cplx_t s;
    for (int k = 0; k < LEN; k++) begin
      pat[k].re = SAMP_W'(next_val(amp));
      pat[k].im = SAMP_W'(next_val(amp));
    end
    for (int r = 0; r < reps; r++) begin
      for (int k = 0; k < LEN; k++) begin
        for (int d = 0; d < DEC_RATE; d++) begin
          s.re = SAMP_W'(int'(pat[k].re) + next_val(3));
          s.im = SAMP_W'(int'(pat[k].im) + next_val(3));
          stim_q.push_back(s);
        end
      end
    end
  endtask

  task automatic send_stream(input cplx_t samp[$]);
    int k;
    k = 0;
    while (k < samp.size()) begin
      @(posedge clk);
      #1;
      stim_rng = xorshift32(stim_rng);
      if ((sent - credits_back < IN_CREDITS) && (stim_rng[2:0] != 3'd0)) begin
        i_valid  = 1'b1;
        i_sample = samp[k];
        sent++;
        k++;
      end else begin
        i_valid = 1'b0;  // out of credits or a random idle cycle
      end
    end
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  task automatic wait_drain();
    repeat (8) @(posedge clk);  // longer than the path from input to FIFO
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic pulse_clear();
    i_clear = 1'b1;
    @(posedge clk);
    #1;
    i_clear = 1'b0;
  endtask

  task automatic run_segment(input cplx_t samp[$], input thres_sel_e sel);
    i_thres_sel = sel;
    model_segment(samp, sel);
    send_stream(samp);
    wait_drain();
    pulse_clear();
  endtask

  ////////////////////////////////////////
  // output credits, monitor and timeout
  ////////////////////////////////////////

  always @(posedge clk) begin
    rst_q = i_rst;
    #1;
    grant_rng = xorshift32(grant_rng);
    if (!rst_q && !grant_hold && (granted - received < 4) &&
        ((grant_rng[7:0] & grant_mask) == 8'd0)) begin
      i_credit = 1'b1;
      granted++;
    end else begin
      i_credit = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (!i_rst) begin
      if (o_credit) begin
        credits_back++;
      end
      if (sent - credits_back >= IN_CREDITS) begin
        grant_hold = 1'b0;  // the sender only starves while input credits are withheld
      end
      if (o_valid) begin
        if (exp_q.size() == 0) begin
          $display("A result with idx %0d arrived at %0t ns when none was due",
                   o_result.idx, $time);
          abort_run();
        end else begin
          check_result(o_result, exp_q.pop_front());
          received++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("The run did not finish within %0d cycles and was stopped", MAX_CYCLES);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    i_rst        = 1'b1;
    i_clear      = 1'b0;
    i_thres_sel  = TH_QUARTER;
    i_valid      = 1'b0;
    i_sample     = '0;
    i_credit     = 1'b0;
    stim_rng     = SEED;
    grant_rng    = SEED;
    grant_mask   = 8'h03;  // about one grant in four cycles
    grant_hold   = 1'b0;
    sent         = 0;
    credits_back = 0;
    granted      = 0;
    received     = 0;
    cycles       = 0;
    repeat (10) @(posedge clk);
    #1;
    i_rst = 1'b0;

    add_noise(256, 7);  // power stays under the floor
    run_segment(stim_q, TH_QUARTER);

    stim_q.delete();
    add_noise(64, 7);
    add_preamble(4, 1000);
    add_noise(64, 7);
    pre_q = stim_q;
    for (int s = 0; s < 4; s++) begin
      run_segment(pre_q, thres_sel_e'(s));
    end

    // output credits stop until the full FIFO holds back input credits, then come rarely
    grant_mask = 8'hff;
    grant_hold = 1'b1;
    stim_q.delete();
    repeat (8) begin
      add_noise(64, 7);
      add_preamble(2, 1000);
    end
    add_noise(64, 7);
    run_segment(stim_q, TH_HALF);
    grant_mask = 8'h03;

    // cut inside a decimation group and a trigger run, then start over
    stim_q.delete();
    add_noise(64, 7);
    add_preamble(2, 1000);
    while (stim_q.size() > CUT_LEN) begin
      void'(stim_q.pop_back());
    end
    run_segment(stim_q, TH_QUARTER);
    run_segment(pre_q, TH_QUARTER);

    repeat (16) @(posedge clk);  // withheld credits come back one per cycle
    check_count(credits_back, sent);
    if ((sent == TOTAL_SAMPLES) && (exp_q.size() == 0)) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Only %0d of %0d samples were sent", sent, TOTAL_SAMPLES);
      abort_run();
    end
  end

endmodule

// ==== preamble_top.f ====
dsp_pkg.sv
detect_pkg.sv
sample_decimate.sv
delay_corr.sv
peak_judge.sv
preamble_top.sv
tb_preamble_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the preamble detector testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_preamble_top \
  -f preamble_top.f \
  --Mdir obj_dir -o tb_preamble_top

status=0
./obj_dir/tb_preamble_top > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Everything OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
